/* bus_periph.sv */
`include "riscv_soc_consts.svh"

module bus_periph (
    input  logic                     clk,
    input  logic                     reset,
    input  riscv_soc_pkg::bus_req_t  bus_req,
    input  riscv_soc_pkg::xlen_t     key_value,      // external key input
    output riscv_soc_pkg::xlen_t     bus_read_data,  // valid the cycle after a read
    output riscv_soc_pkg::xlen_t     art_data,
    output logic                     art_valid       // one cycle pulse
);
    import riscv_soc_pkg::*;

    logic key_hit;
    logic art_hit;
    logic art_write;

    // address decode
    always_comb begin
        key_hit   = (bus_req.address == `KEY_BASE);
        art_hit   = (bus_req.address == `ART_BASE);
        art_write = bus_req.write_enable && art_hit;
    end

    // read path, key sampled on the strobe
    always_ff @(posedge clk) begin
        if (bus_req.read_enable) begin
            if (key_hit) begin
                bus_read_data <= key_value;
            end else if (art_hit) begin
                bus_read_data <= art_data;  // art port reads back
            end
        end
    end

    // art output register
    always_ff @(posedge clk) begin
        if (art_write) begin
            art_data <= bus_req.write_data;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            art_valid <= 1'b0;
        end else begin
            art_valid <= art_write;  // marks the cycle art_data changed
        end
    end

    // core only strobes addresses decoded here
    a_strobe_mapped: assert property (@(posedge clk) disable iff (!reset)
        (bus_req.read_enable || bus_req.write_enable) |-> (key_hit || art_hit));

endmodule

/* csr_file.sv */
`include "riscv_soc_consts.svh"

module csr_file (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 trap_enter,   // irq accepted this cycle
    input  logic                 trap_return,  // mret executed this cycle
    input  riscv_soc_pkg::xlen_t trap_pc,      // address to resume at
    output riscv_soc_pkg::xlen_t mepc,
    output logic                 mie_enabled
);
    import riscv_soc_pkg::*;

    xlen_t mepc_q;
    logic  mie_q;         // mstatus.MIE
    logic  mpie_q;        // mstatus.MPIE
    xlen_t mstatus_view;  // assembled mstatus word

    // csr read view
    // other mstatus bits read as zero
    function automatic xlen_t csr_read(input csr_addr_t index);
        xlen_t value;
        value = '0;
        case (index)
            `CSR_MEPC: begin
                value = mepc_q;
            end
            `CSR_MSTATUS: begin
                value[`MSTATUS_MIE_BIT]  = mie_q;
                value[`MSTATUS_MPIE_BIT] = mpie_q;
            end
            default: begin
                value = '0;
            end
        endcase
        return value;
    endfunction

    always_comb begin
        mepc         = csr_read(`CSR_MEPC);
        mstatus_view = csr_read(`CSR_MSTATUS);
        mie_enabled  = mstatus_view[`MSTATUS_MIE_BIT];  // gates irq entry in core
    end

    // interrupts come up enabled
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mie_q  <= 1'b1;
            mpie_q <= 1'b1;
        end else if (trap_enter) begin
            mpie_q <= mie_q;   // remember enable state
            mie_q  <= 1'b0;    // no nesting inside the handler
        end else if (trap_return) begin
            mie_q  <= mpie_q;  // back to pre-trap state
            mpie_q <= 1'b1;
        end
    end

    // resume address, only written on entry
    always_ff @(posedge clk) begin
        if (trap_enter) begin
            mepc_q <= trap_pc;
        end
    end

    // core never enters and returns in the same cycle
    a_trap_exclusive: assert property (@(posedge clk) disable iff (!reset)
        !(trap_enter && trap_return));

endmodule

/* inst_rom.sv */
`include "riscv_soc_consts.svh"

module inst_rom (
    input  riscv_soc_pkg::xlen_t pc,
    output riscv_soc_pkg::inst_t instruction
);
    import riscv_soc_pkg::*;

    localparam int       INDEX_W      = $clog2(`ROM_DEPTH);
    localparam int       REGION_W     = INDEX_W - 1;     // word offset bits per region
    localparam int       REGION_WORDS = `ROM_DEPTH / 2;
    localparam reg_idx_t ISR_RD       = 5'd5;            // handler lui target
    localparam int       MAIN_RD_BASE = 6;               // main loop uses x6 and up
    localparam int       MAIN_RD_SPAN = 26;

    inst_t              rom [`ROM_DEPTH];
    logic               main_region;
    logic [INDEX_W-1:0] rom_index;

    // lower half holds the handler, upper half the main loop
    // main code wraps inside its own half
    always_comb begin
        main_region = (pc >= `RAM_BASE);
        rom_index   = {main_region, pc[REGION_W+1:2]};
        instruction = rom[rom_index];  // combinational read
    end

    initial begin
        // handler tail falls into mret, main half is all lui
        for (int i = 0; i < REGION_WORDS; i++) begin
            rom[i] = `INST_MRET;
            rom[REGION_WORDS + i] = {20'(i + 1),
                                     reg_idx_t'(MAIN_RD_BASE + (i % MAIN_RD_SPAN)),
                                     `OPC_LUI};
        end

        // interrupt service routine at address 0
        rom[0] = {`ISR_LUI_IMM, ISR_RD, `OPC_LUI};  // x5 gets the fixed word
        rom[1] = `INST_STORE_ART;                   // first art write
        rom[2] = `INST_LOAD_KEY;                    // x5 gets the key
        rom[3] = `INST_STORE_ART;                   // second art write
        rom[4] = `INST_MRET;                        // back to main
    end

endmodule

/* riscv64.sv */
`include "riscv_soc_consts.svh"

module riscv64 (
    input  logic                     clk,
    input  logic                     reset,
    input  riscv_soc_pkg::inst_t     instruction,       // rom word at pc
    input  riscv_soc_pkg::irq_vec_t  interrupt_vector,  // level, held until ack
    input  riscv_soc_pkg::xlen_t     bus_read_data,
    output riscv_soc_pkg::xlen_t     pc,
    output riscv_soc_pkg::bus_req_t  bus_req,
    output logic                     interrupt_ack,     // one cycle pulse
    output logic                     heartbeat
);
    import riscv_soc_pkg::*;

    localparam reg_idx_t KEY_RD = 5'd5;  // fixed register of the custom load and store
    localparam bus_req_t BUS_IDLE = '{
        address:      `RAM_BASE,
        write_data:   '0,
        write_enable: 1'b0,
        read_enable:  1'b0
    };

    inst_t       ir;          // if to exe register
    logic        bubble;      // ir holds a wrongly fetched word
    load_state_t load_state;
    xlen_t       rf [32];     // x0 never written

    // csr side
    xlen_t       mepc;
    logic        mie_enabled;
    logic        trap_enter;
    logic        trap_return;
    xlen_t       trap_pc;

    // exe decode
    logic        is_lui;
    logic        is_mret;
    logic        is_load;
    logic        is_store;
    reg_idx_t    rd;
    xlen_t       imm_u;
    logic        irq_take;
    logic        exe_valid;

    // register file write port
    logic        rf_we;
    reg_idx_t    rf_waddr;
    xlen_t       rf_wdata;

    always_comb begin
        is_lui   = (ir[6:0] == `OPC_LUI);
        is_mret  = (ir == `INST_MRET);
        is_load  = (ir == `INST_LOAD_KEY);
        is_store = (ir == `INST_STORE_ART);
        rd       = ir[11:7];
        imm_u    = {{32{ir[31]}}, ir[31:12], 12'h000};  // sign extended upper imm
        // held off while a load is in flight so mepc stays exact
        irq_take = (interrupt_vector == `IRQ_EXTERNAL) && mie_enabled
                   && (load_state == LOAD_IDLE);
        exe_valid = !bubble && !irq_take;  // accepted irq squashes ir, replayed later
    end

    always_comb begin
        rf_we    = 1'b0;
        rf_waddr = rd;
        rf_wdata = imm_u;
        if (exe_valid && is_lui && rd != '0) begin
            rf_we = 1'b1;
        end else if (exe_valid && is_load && load_state == LOAD_WAIT) begin
            rf_we    = 1'b1;          // second pass, key has arrived
            rf_waddr = KEY_RD;
            rf_wdata = bus_read_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rf_we) begin
            rf[rf_waddr] <= rf_wdata;
        end
    end

    assign trap_enter  = irq_take;
    assign trap_return = exe_valid && is_mret;
    assign trap_pc     = bubble ? pc : pc - 64'd4;  // ir's own address unless ir is junk

    csr_file u_csr (
        .clk         (clk),
        .reset       (reset),
        .trap_enter  (trap_enter),
        .trap_return (trap_return),
        .trap_pc     (trap_pc),
        .mepc        (mepc),
        .mie_enabled (mie_enabled)
    );

    // fetch stage
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir        <= `INST_NOP;
            heartbeat <= 1'b0;
        end else begin
            ir        <= instruction;  // word at pc, executed next cycle
            heartbeat <= ~heartbeat;
        end
    end

    // execute stage, pc and bus control
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc            <= `RAM_BASE;
            bubble        <= 1'b1;  // reset nop is no real instruction
            load_state    <= LOAD_IDLE;
            bus_req       <= BUS_IDLE;
            interrupt_ack <= 1'b0;
        end else begin
            pc            <= pc + 64'd4;  // sequential by default
            bubble        <= 1'b0;
            bus_req       <= BUS_IDLE;    // strobes drop after one cycle
            interrupt_ack <= 1'b0;
            if (irq_take) begin
                pc            <= `ISR_ADDR;
                bubble        <= 1'b1;    // flush word fetched at old pc
                interrupt_ack <= 1'b1;
            end else if (exe_valid) begin
                if (is_mret) begin
                    pc     <= mepc;
                    bubble <= 1'b1;
                end else if (is_load) begin
                    if (load_state == LOAD_IDLE) begin
                        bus_req.address     <= `KEY_BASE;
                        bus_req.read_enable <= 1'b1;
                        pc                  <= pc - 64'd4;  // refetch the load
                        bubble              <= 1'b1;
                        load_state          <= LOAD_WAIT;
                    end else begin
                        load_state <= LOAD_IDLE;  // x5 written this cycle
                    end
                end else if (is_store) begin
                    bus_req.address      <= `ART_BASE;
                    bus_req.write_data   <= rf[KEY_RD];
                    bus_req.write_enable <= 1'b1;
                end
            end
        end
    end

    a_strobe_exclusive: assert property (@(posedge clk) disable iff (!reset)
        !(bus_req.read_enable && bus_req.write_enable));

    // ack only when mstatus allowed entry one cycle earlier
    a_ack_needs_mie: assert property (@(posedge clk) disable iff (!reset)
        interrupt_ack |-> $past(mie_enabled));

endmodule

/* riscv_soc.f */
+incdir+.
riscv_soc_pkg.sv
csr_file.sv
riscv64.sv
inst_rom.sv
bus_periph.sv
riscv_soc.sv
tb_clock_gen.sv
tb_riscv_soc.sv

/* riscv_soc.sv */
module riscv_soc (
    input  logic                     clk,
    input  logic                     reset,
    input  riscv_soc_pkg::xlen_t     key_value,
    input  riscv_soc_pkg::irq_vec_t  interrupt_vector,
    output logic                     interrupt_ack,
    output logic                     heartbeat,
    output riscv_soc_pkg::xlen_t     art_data,
    output logic                     art_valid,
    output riscv_soc_pkg::xlen_t     pc
);
    import riscv_soc_pkg::*;

    inst_t    instruction;    // rom to core
    bus_req_t bus_req;        // core to peripherals
    xlen_t    bus_read_data;  // peripherals to core

    riscv64 u_core (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .interrupt_vector (interrupt_vector),
        .bus_read_data    (bus_read_data),
        .pc               (pc),
        .bus_req          (bus_req),
        .interrupt_ack    (interrupt_ack),
        .heartbeat        (heartbeat)
    );

    inst_rom u_rom (
        .pc          (pc),
        .instruction (instruction)
    );

    bus_periph u_periph (
        .clk           (clk),
        .reset         (reset),
        .bus_req       (bus_req),
        .key_value     (key_value),
        .bus_read_data (bus_read_data),
        .art_data      (art_data),
        .art_valid     (art_valid)
    );

endmodule

/* riscv_soc_consts.svh */
`ifndef RISCV_SOC_CONSTS_SVH
`define RISCV_SOC_CONSTS_SVH

// memory map
`define RAM_BASE         64'h0000_0000_8000_0000  // reset pc and idle bus address
`define KEY_BASE         64'h0000_0000_1000_0000  // key input register
`define ART_BASE         64'h0000_0000_1000_0008  // art output port
`define ISR_ADDR         64'h0000_0000_0000_0000  // external irq entry

// instruction encodings the core knows
`define INST_LOAD_KEY    32'hFFFF_FFFF   // custom load of key into x5
`define INST_STORE_ART   32'hFFFF_FF7F   // custom store of x5, bit 7 clear
`define INST_MRET        32'h0000_0000   // reduced mret
`define INST_NOP         32'h0000_0013   // addi x0 form, ignored by decode
`define OPC_LUI          7'b0110111
`define ISR_LUI_IMM      20'hA5C3E       // upper immediate of the handler lui

// csr indices and mstatus bits
`define CSR_MSTATUS      12'h300
`define CSR_MEPC         12'h341
`define MSTATUS_MIE_BIT  3
`define MSTATUS_MPIE_BIT 7

// interrupt request value on the 4-bit vector
`define IRQ_EXTERNAL     4'd1

`define ROM_DEPTH        256             // words, handler half and main half

`endif

/* riscv_soc_pkg.sv */
package riscv_soc_pkg;

    // widths with a meaning
    typedef logic [63:0] xlen_t;      // data or address word
    typedef logic [31:0] inst_t;      // one instruction
    typedef logic [4:0]  reg_idx_t;   // register file index
    typedef logic [11:0] csr_addr_t;  // csr index
    typedef logic [3:0]  irq_vec_t;   // external interrupt vector

    // core to peripheral request
    // registered in the core, strobes are single cycle
    // address parks at the ram base while idle
    typedef struct packed {
        xlen_t address;       // peripheral address
        xlen_t write_data;    // store payload
        logic  write_enable;  // store strobe
        logic  read_enable;   // load strobe
    } bus_req_t;              // 130 bits

    // custom load runs two passes through exe
    //   idle : next load issues the read and replays itself
    //   wait : read data lands this pass
    typedef enum logic {
        LOAD_IDLE,
        LOAD_WAIT
    } load_state_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# build and run the riscv_soc testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -f riscv_soc.f --top-module tb_riscv_soc -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/Vtb_riscv_soc
status=$?
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit $status
fi

exit 0

/* tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD = 40  // time units per clock cycle
) (
    output logic clk
);

    // free running, starts low so the first rising edge is half a period in
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

/* tb_riscv_soc.sv */
`include "riscv_soc_consts.svh"

module tb_riscv_soc;
    import riscv_soc_pkg::*;

    localparam int RESET_CYCLES   = 10;
    localparam int ACK_TIMEOUT    = 40;  // cycles from raise to ack
    localparam int ART_TIMEOUT    = 40;  // cycles per art write
    localparam int REGION_TIMEOUT = 20;  // cycles until pc is back in main code
    localparam int IRQ_ROUNDS     = 20;

    logic        clk;
    logic        reset;
    xlen_t       key_value;
    irq_vec_t    interrupt_vector;
    logic        interrupt_ack;
    logic        heartbeat;
    xlen_t       art_data;
    logic        art_valid;
    xlen_t       pc;

    logic [15:0] lfsr_state;
    xlen_t       current_key;  // key held during the interrupt being serviced
    int          art_count;    // art writes seen by the checker
    int          irq_raised;   // interrupts requested so far
    logic        prev_heartbeat;
    logic        heartbeat_seen;

    tb_clock_gen #(.PERIOD(40)) u_clk (.clk(clk));

    riscv_soc u_dut (
        .clk              (clk),
        .reset            (reset),
        .key_value        (key_value),
        .interrupt_vector (interrupt_vector),
        .interrupt_ack    (interrupt_ack),
        .heartbeat        (heartbeat),
        .art_data         (art_data),
        .art_valid        (art_valid),
        .pc               (pc)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input xlen_t got, input xlen_t exp);
        report_failure($sformatf("Error at time %0t: %s is 0x%0h, expected 0x%0h",
                                 $time, name, got, exp));
    endtask

    // galois lfsr with taps at 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hB400;
        end
        return next;
    endfunction

    task automatic draw_key(output xlen_t key);
        key = '0;
        for (int i = 0; i < 64; i++) begin
            key        = {key[62:0], lfsr_state[0]};  // one step per key bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // handler writes lui x5 first and then the loaded key
    function automatic xlen_t expected_art(input int write_index, input xlen_t key);
        logic [19:0]        imm;
        logic signed [31:0] word;  // 32 bit lui result
        imm  = `ISR_LUI_IMM;
        word = {imm, 12'h000};
        if (write_index == 0) begin
            return xlen_t'(word);  // signed cast widens as rv64 lui does
        end
        return key;
    endfunction

    // every art pulse against the reference
    always @(negedge clk) begin : art_check
        xlen_t expected;
        if (reset && art_valid) begin
            expected = expected_art(art_count % 2, current_key);
            assert (art_count < 2 * irq_raised)
                else report_failure("art write seen with no interrupt left to service");
            assert (art_data == expected)
                else value_error("art_data", art_data, expected);
            art_count++;
        end
    end

    always @(negedge clk) begin
        if (reset) begin
            if (heartbeat_seen) begin
                assert (heartbeat != prev_heartbeat)
                    else value_error("heartbeat", 64'(heartbeat), 64'(!prev_heartbeat));
            end
            prev_heartbeat = heartbeat;
            heartbeat_seen = 1'b1;
        end
    end

    task automatic verify_reset_state();
        assert (pc == `RAM_BASE) else value_error("pc", pc, `RAM_BASE);
        assert (heartbeat == 1'b0) else value_error("heartbeat", 64'(heartbeat), 64'd0);
        assert (interrupt_ack == 1'b0)
            else value_error("interrupt_ack", 64'(interrupt_ack), 64'd0);
        assert (art_valid == 1'b0) else value_error("art_valid", 64'(art_valid), 64'd0);
    endtask

    // pc walks main code word by word while no interrupt is raised
    task automatic track_pc_steps(input int steps);
        xlen_t prev_pc;
        prev_pc = pc;
        for (int i = 0; i < steps; i++) begin
            @(negedge clk);
            assert (pc == prev_pc + 64'd4) else value_error("pc", pc, prev_pc + 64'd4);
            assert (interrupt_ack == 1'b0)
                else value_error("interrupt_ack", 64'(interrupt_ack), 64'd0);
            prev_pc = pc;
        end
    endtask

    task automatic raise_irq();
        interrupt_vector = `IRQ_EXTERNAL;
        irq_raised++;
    endtask

    // art writes seen before the ack are counted for the caller
    task automatic await_ack(output int writes);
        int   cycles;
        logic got_ack;
        writes  = 0;
        cycles  = 0;
        got_ack = 1'b0;
        while (!got_ack) begin
            @(negedge clk);
            cycles++;
            if (art_valid) begin
                writes++;
            end
            if (interrupt_ack) begin
                got_ack = 1'b1;
            end else if (cycles >= ACK_TIMEOUT) begin
                report_failure("interrupt was never acknowledged");
            end
        end
    endtask

    // vector drops once the ack is seen and the ack must be a single pulse
    task automatic clear_after_ack();
        interrupt_vector = '0;
        @(negedge clk);
        assert (interrupt_ack == 1'b0)
            else value_error("interrupt_ack", 64'(interrupt_ack), 64'd0);
    endtask

    task automatic count_art_writes(input int target);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while (seen < target) begin
            @(negedge clk);
            cycles++;
            if (art_valid) begin
                seen++;
                cycles = 0;
            end else if (cycles >= ART_TIMEOUT) begin
                report_failure("handler stopped before writing both art words");
            end
        end
    endtask

    // current cycle counts too since mret may already have landed
    task automatic expect_main_region();
        int cycles;
        cycles = 0;
        while (pc < `RAM_BASE) begin
            if (cycles >= REGION_TIMEOUT) begin
                report_failure("pc did not return to the main region after mret");
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    task automatic service_interrupt();
        xlen_t key;
        int    writes;
        draw_key(key);
        current_key = key;
        key_value   = key;  // stable until the next interrupt
        raise_irq();
        await_ack(writes);
        assert (writes == 0) else report_failure("art write seen before the ack");
        clear_after_ack();
        count_art_writes(2);
        expect_main_region();
    endtask

    // second request inside the handler waits for mret
    task automatic run_nested_interrupt();
        xlen_t key;
        int    writes;
        draw_key(key);
        current_key = key;
        key_value   = key;
        raise_irq();
        await_ack(writes);
        assert (writes == 0) else report_failure("art write seen before the ack");
        clear_after_ack();
        raise_irq();  // mie is 0 here
        await_ack(writes);
        assert (writes == 2)
            else report_failure("second interrupt acknowledged before the handler returned");
        clear_after_ack();
        count_art_writes(2);
        expect_main_region();
    endtask

    initial begin
        reset            = 1'b0;
        key_value        = '0;
        interrupt_vector = '0;
        lfsr_state       = 16'd20297;
        current_key      = '0;
        art_count        = 0;
        irq_raised       = 0;
        prev_heartbeat   = 1'b0;
        heartbeat_seen   = 1'b0;

        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b1;  // released on a falling edge
        verify_reset_state();
        track_pc_steps(20);

        service_interrupt();
        track_pc_steps(8);   // plain fetch again after the handler
        run_nested_interrupt();

        for (int round = 0; round < IRQ_ROUNDS; round++) begin
            repeat (3) @(negedge clk);  // short gap of main code
            service_interrupt();
        end

        repeat (20) @(negedge clk);  // any stray art write shows up here
        if (art_count == 2 * irq_raised) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            report_failure($sformatf("Error at time %0t: art write count is %0d, expected %0d",
                                     $time, art_count, 2 * irq_raised));
        end
    end

endmodule
